// ==== common/phy_types_pkg.sv ====
/*
 * phy_types_pkg
 * beat-level types for the byte lane data path: the per-cycle write word,
 * the word driven toward the pads and the received word
 */
package phy_types_pkg;

    localparam int BEATS = 4;            // beats per clk_div cycle
    localparam int DQ_PINS = 8;          // data pins in one byte lane
    localparam int HIST_BEATS = 3 * BEATS; // current word plus two older words

    typedef logic [BEATS-1:0] beats_t;   // bit k is beat k, beat 0 goes out first

    typedef struct packed {
        logic [DQ_PINS*BEATS-1:0] dq;    // beat-major, byte k is beat k
        beats_t dm;
        beats_t dq_oe_n;                 // active low, shared by dq and dm
        beats_t dqs;
        beats_t dqs_oe_n;
    } lane_tx_t;

    typedef struct packed {
        logic [DQ_PINS*BEATS-1:0] dq;
        beats_t dm;
        beats_t dq_oe_n;
        beats_t dqs;
        beats_t dqs_oe_n;
        logic odt_off_dq;                // termination off on dq and dm
        logic odt_off_dqs;               // termination off on the strobe
    } lane_pad_out_t;

    typedef struct packed {
        logic [DQ_PINS*BEATS-1:0] dq;
        beats_t dqs;                     // received strobe beats for training
    } lane_rx_t;

    // picks the 4 beats that are dly beats late out of a 12-beat history
    // hist = {current, previous, the one before}, so beat j comes from hist[8+j-dly]
    function automatic beats_t beat_window(input logic [HIST_BEATS-1:0] hist,
                                           input logic [2:0] dly);
        beats_t win;
        int j;
        for (j = 0; j < BEATS; j++) begin
            win[j] = hist[2*BEATS + j - int'(dly)];
        end
        return win;
    endfunction

endpackage

// ==== common/phy_regs_pkg.sv ====
/*
 * phy_regs_pkg
 * register map of the delay configuration port, delay targets and
 * the bundle of active delays handed to the byte lane
 */
package phy_regs_pkg;

    localparam int NUM_ODLY = 10;            // dq0..dq7, dqs, dm
    localparam int NUM_IDLY = 9;             // dq0..dq7, dqs (dm is output only)

    localparam logic [7:0] REG_ODLY_BASE = 8'h00; // output delays, index*4
    localparam logic [7:0] REG_IDLY_BASE = 8'h40; // input delays, index*4
    localparam logic [7:0] REG_SET = 8'h80;       // commit pending -> active
    localparam logic [7:0] REG_ODT = 8'h84;       // bit0 dq/dm, bit1 dqs
    localparam logic [7:0] REG_BANK_MASK = 8'hc0; // selects the delay bank

    typedef logic [7:0] dly_t;               // only [2:0] sets the beat delay

    typedef enum logic [3:0] {
        DLY_DQ0 = 4'd0,
        DLY_DQ1 = 4'd1,
        DLY_DQ2 = 4'd2,
        DLY_DQ3 = 4'd3,
        DLY_DQ4 = 4'd4,
        DLY_DQ5 = 4'd5,
        DLY_DQ6 = 4'd6,
        DLY_DQ7 = 4'd7,
        DLY_DQS = 4'd8,
        DLY_DM  = 4'd9
    } dly_target_e;

    typedef enum logic {
        OUT_DLY,
        IN_DLY
    } reg_dir_e;

    typedef struct packed {
        dly_t [NUM_ODLY-1:0] odly;           // indexed by dly_target_e
        dly_t [NUM_IDLY-1:0] idly;
    } dly_bus_t;

endpackage

// ==== logic/apb_delay_regs.sv ====
/*
 * apb_delay_regs
 * APB slave with pending and active per-pin delay registers, a SET register
 * that commits all pending values at once, and the two ODT disable bits
 */
module apb_delay_regs (
    input  logic                   clk_div,
    input  logic                   rst,
    input  logic [7:0]             paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output phy_regs_pkg::dly_bus_t delays,
    output logic                   odt_off_dq,
    output logic                   odt_off_dqs
);
    import phy_regs_pkg::*;

    typedef enum logic [1:0] {
        ACC_DLY,                                 // one of the delay registers
        ACC_SET,
        ACC_ODT,
        ACC_BAD                                  // unmapped, answers with pslverr
    } acc_e;

    acc_e                acc;
    reg_dir_e            dir;
    dly_target_e         tgt;
    logic                access;                 // apb access phase
    logic                wr_ok;
    dly_t [NUM_ODLY-1:0] odly_pend;
    dly_t [NUM_IDLY-1:0] idly_pend;

    // address decode
    always_comb begin
        acc = ACC_BAD;
        dir = OUT_DLY;
        tgt = dly_target_e'(paddr[5:2]);         // word index inside a bank
        if (paddr == REG_SET) begin
            acc = ACC_SET;
        end else if (paddr == REG_ODT) begin
            acc = ACC_ODT;
        end else if (paddr[1:0] == 2'b00) begin
            if ((paddr & REG_BANK_MASK) == REG_ODLY_BASE) begin
                dir = OUT_DLY;
                if (paddr[5:2] < NUM_ODLY) acc = ACC_DLY;
            end else if ((paddr & REG_BANK_MASK) == REG_IDLY_BASE) begin
                dir = IN_DLY;
                if (paddr[5:2] < NUM_IDLY) acc = ACC_DLY; // no dm input delay
            end
        end
    end

    assign pready = 1'b1;                        // zero wait states
    assign access = psel & penable & pready;
    assign wr_ok = access & pwrite & (acc != ACC_BAD);
    assign pslverr = access & (acc == ACC_BAD);

    // read mux returns active values
    always_comb begin
        prdata = '0;
        case (acc)
            ACC_DLY: begin
                if (dir == OUT_DLY) prdata[7:0] = delays.odly[tgt];
                else prdata[7:0] = delays.idly[tgt];
            end
            ACC_ODT: prdata[1:0] = {odt_off_dqs, odt_off_dq};
            default: prdata = '0;                // SET reads as zero
        endcase
    end

    always_ff @(posedge clk_div) begin
        if (rst) begin
            odly_pend <= '0;
            idly_pend <= '0;
            delays <= '0;                        // all pins start undelayed
            odt_off_dq <= 1'b1;                  // termination off until told
            odt_off_dqs <= 1'b1;
        end else if (wr_ok) begin
            case (acc)
                ACC_DLY: begin
                    if (dir == OUT_DLY) odly_pend[tgt] <= pwdata[7:0];
                    else idly_pend[tgt] <= pwdata[7:0];
                end
                ACC_SET: begin
                    delays.odly <= odly_pend;    // every pin switches together
                    delays.idly <= idly_pend;
                end
                ACC_ODT: begin
                    odt_off_dq <= pwdata[0];
                    odt_off_dqs <= pwdata[1];
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== byte_lane/lane_bit_slice.sv ====
/*
 * lane_bit_slice
 * one data pin: beat delay line on the serializer side with the tristate
 * kept aligned to its data, plus an optional delayed receive path
 */
module lane_bit_slice #(
    parameter bit HAS_INPUT = 1'b1             // 0 removes the receive path
) (
    input  logic               clk_div,
    input  logic               rst,
    input  logic [3:0]         tx_beats,
    input  logic [3:0]         tx_oe_n,
    input  phy_regs_pkg::dly_t odly,
    input  phy_regs_pkg::dly_t idly,
    output logic [3:0]         pad_out,
    output logic [3:0]         pad_oe_n,
    input  logic [3:0]         pad_in,
    output logic [3:0]         rx_beats
);
    import phy_types_pkg::*;

    beats_t tx_p1;                               // previous word
    beats_t tx_p2;                               // word before that
    beats_t oe_p1;
    beats_t oe_p2;

    // history of older words, data side
    always_ff @(posedge clk_div) begin
        tx_p1 <= tx_beats;
        tx_p2 <= tx_p1;
    end

    always_ff @(posedge clk_div) begin
        if (rst) begin
            oe_p1 <= '1;                         // history reads as tristate
            oe_p2 <= '1;
            pad_out <= '0;
            pad_oe_n <= '1;
        end else begin
            oe_p1 <= tx_oe_n;
            oe_p2 <= oe_p1;
            // same shift for data and enable keeps the window around the data
            pad_out <= beat_window({tx_beats, tx_p1, tx_p2}, odly[2:0]);
            pad_oe_n <= beat_window({tx_oe_n, oe_p1, oe_p2}, odly[2:0]);
        end
    end

    if (HAS_INPUT) begin : g_rx
        beats_t in_r;                            // pad word, registered
        beats_t in_p1;
        beats_t in_p2;

        always_ff @(posedge clk_div) begin
            in_r <= pad_in;
            in_p1 <= in_r;
            in_p2 <= in_p1;
        end

        always_ff @(posedge clk_div) begin
            if (rst) begin
                rx_beats <= '0;
            end else begin
                rx_beats <= beat_window({in_r, in_p1, in_p2}, idly[2:0]);
            end
        end
    end else begin : g_no_rx
        assign rx_beats = '0;                    // output only pin
    end

endmodule

// ==== byte_lane/dqs_slice.sv ====
/*
 * dqs_slice
 * strobe pin: delayed output strobe with aligned tristate, and the delayed
 * received strobe beats returned to the controller for training
 */
module dqs_slice (
    input  logic               clk_div,
    input  logic               rst,
    input  logic [3:0]         tx_beats,
    input  logic [3:0]         tx_oe_n,
    input  phy_regs_pkg::dly_t odly,
    input  phy_regs_pkg::dly_t idly,
    output logic [3:0]         pad_out,
    output logic [3:0]         pad_oe_n,
    input  logic [3:0]         pad_in,
    output logic [3:0]         rx_beats
);
    import phy_types_pkg::*;

    beats_t dqs_p1;                              // strobe history
    beats_t dqs_p2;
    beats_t oe_p1;
    beats_t oe_p2;
    beats_t rcv_r;                               // received strobe, registered
    beats_t rcv_p1;
    beats_t rcv_p2;

    always_ff @(posedge clk_div) begin
        dqs_p1 <= tx_beats;
        dqs_p2 <= dqs_p1;
        rcv_r <= pad_in;
        rcv_p1 <= rcv_r;
        rcv_p2 <= rcv_p1;
    end

    always_ff @(posedge clk_div) begin
        if (rst) begin
            oe_p1 <= '1;
            oe_p2 <= '1;
            pad_out <= '0;                       // strobe parked low
            pad_oe_n <= '1;                      // and not driven
            rx_beats <= '0;
        end else begin
            oe_p1 <= tx_oe_n;
            oe_p2 <= oe_p1;
            pad_out <= beat_window({tx_beats, dqs_p1, dqs_p2}, odly[2:0]);
            pad_oe_n <= beat_window({tx_oe_n, oe_p1, oe_p2}, odly[2:0]);
            rx_beats <= beat_window({rcv_r, rcv_p1, rcv_p2}, idly[2:0]);
        end
    end

endmodule

// ==== byte_lane/byte_lane.sv ====
/*
 * byte_lane
 * one DDR3 byte lane at beat level: registers the write word and ODT bits,
 * splits the beat-major bytes into per-pin beats for the DQ, DM and DQS
 * slices and packs the results back toward the pads and the controller
 */
module byte_lane #(
    parameter int NUM_DQ = 8
) (
    input  logic                        clk_div,
    input  logic                        rst,
    input  phy_types_pkg::lane_tx_t     tx,
    input  phy_regs_pkg::dly_bus_t      delays,
    input  logic                        odt_off_dq,
    input  logic                        odt_off_dqs,
    output phy_types_pkg::lane_pad_out_t pad,
    input  logic [31:0]                 dq_pad_in,
    input  logic [3:0]                  dqs_pad_in,
    output phy_types_pkg::lane_rx_t     rx
);
    import phy_types_pkg::*;
    import phy_regs_pkg::*;

    lane_tx_t tx_r;                              // input word, one cycle late
    logic     odt_dq_r;
    logic     odt_dqs_r;

    beats_t dq_tx  [DQ_PINS];                    // per-pin beats
    beats_t dq_out [DQ_PINS];
    beats_t dq_oe  [DQ_PINS];
    beats_t dq_in  [DQ_PINS];
    beats_t dq_rx  [DQ_PINS];
    beats_t dm_out;
    beats_t dm_oe;
    beats_t dqs_out;
    beats_t dqs_oe;
    beats_t dqs_rx;
    beats_t oe_all;                              // combined dq/dm tristate
    logic [DQ_PINS*BEATS-1:0] pad_dq;
    logic [DQ_PINS*BEATS-1:0] rx_dq;

    always_ff @(posedge clk_div) begin
        if (rst) begin
            tx_r.dq <= '0;
            tx_r.dm <= '0;
            tx_r.dqs <= '0;
            tx_r.dq_oe_n <= '1;                  // pads tristated
            tx_r.dqs_oe_n <= '1;
            odt_dq_r <= 1'b1;
            odt_dqs_r <= 1'b1;
        end else begin
            tx_r <= tx;
            odt_dq_r <= odt_off_dq;
            odt_dqs_r <= odt_off_dqs;
        end
    end

    for (genvar i = 0; i < DQ_PINS; i++) begin : g_dq
        // byte b of the word carries beat b of every pin
        assign dq_tx[i] = {tx_r.dq[i+3*DQ_PINS], tx_r.dq[i+2*DQ_PINS],
                           tx_r.dq[i+DQ_PINS], tx_r.dq[i]};
        assign dq_in[i] = {dq_pad_in[i+3*DQ_PINS], dq_pad_in[i+2*DQ_PINS],
                           dq_pad_in[i+DQ_PINS], dq_pad_in[i]};
        if (i < NUM_DQ) begin : g_pin
            lane_bit_slice #(
                .HAS_INPUT(1'b1)
            ) dq_slice_inst (
                .clk_div  (clk_div),
                .rst      (rst),
                .tx_beats (dq_tx[i]),
                .tx_oe_n  (tx_r.dq_oe_n),
                .odly     (delays.odly[i]),
                .idly     (delays.idly[i]),
                .pad_out  (dq_out[i]),
                .pad_oe_n (dq_oe[i]),
                .pad_in   (dq_in[i]),
                .rx_beats (dq_rx[i])
            );
        end else begin : g_unused
            assign dq_out[i] = '0;               // pin not fitted, park it
            assign dq_oe[i] = '1;
            assign dq_rx[i] = '0;
        end
        for (genvar b = 0; b < BEATS; b++) begin : g_beat
            assign pad_dq[b*DQ_PINS+i] = dq_out[i][b];
            assign rx_dq[b*DQ_PINS+i] = dq_rx[i][b];
        end
    end

    lane_bit_slice #(
        .HAS_INPUT(1'b0)                         // dm is write only
    ) dm_slice_inst (
        .clk_div  (clk_div),
        .rst      (rst),
        .tx_beats (tx_r.dm),
        .tx_oe_n  (tx_r.dq_oe_n),
        .odly     (delays.odly[DLY_DM]),
        .idly     ('0),
        .pad_out  (dm_out),
        .pad_oe_n (dm_oe),
        .pad_in   ('0),
        .rx_beats ()
    );

    dqs_slice dqs_slice_inst (
        .clk_div  (clk_div),
        .rst      (rst),
        .tx_beats (tx_r.dqs),
        .tx_oe_n  (tx_r.dqs_oe_n),
        .odly     (delays.odly[DLY_DQS]),
        .idly     (delays.idly[DLY_DQS]),
        .pad_out  (dqs_out),
        .pad_oe_n (dqs_oe),
        .pad_in   (dqs_pad_in),
        .rx_beats (dqs_rx)
    );

    // a beat is driven when any dq or dm pin drives it
    always_comb begin
        oe_all = dm_oe;
        for (int i = 0; i < DQ_PINS; i++) begin
            oe_all = oe_all & dq_oe[i];
        end
    end

    assign pad = '{dq: pad_dq, dm: dm_out, dq_oe_n: oe_all, dqs: dqs_out,
                   dqs_oe_n: dqs_oe, odt_off_dq: odt_dq_r, odt_off_dqs: odt_dqs_r};
    assign rx = '{dq: rx_dq, dqs: dqs_rx};

endmodule

// ==== logic/ddr_lane_top.sv ====
/*
 * ddr_lane_top
 * byte lane with its APB delay configuration block
 */
module ddr_lane_top #(
    parameter int NUM_DQ = 8
) (
    input  logic                         clk_div,
    input  logic                         rst,
    input  logic [7:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  phy_types_pkg::lane_tx_t      tx,
    output phy_types_pkg::lane_pad_out_t pad,
    input  logic [31:0]                  dq_pad_in,
    input  logic [3:0]                   dqs_pad_in,
    output phy_types_pkg::lane_rx_t      rx
);
    import phy_regs_pkg::*;

    dly_bus_t delays;                            // active delays, all pins
    logic     odt_off_dq;
    logic     odt_off_dqs;

    apb_delay_regs apb_delay_regs_inst (
        .clk_div     (clk_div),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .delays      (delays),
        .odt_off_dq  (odt_off_dq),
        .odt_off_dqs (odt_off_dqs)
    );

    byte_lane #(
        .NUM_DQ(NUM_DQ)
    ) byte_lane_inst (
        .clk_div     (clk_div),
        .rst         (rst),
        .tx          (tx),
        .delays      (delays),
        .odt_off_dq  (odt_off_dq),
        .odt_off_dqs (odt_off_dqs),
        .pad         (pad),
        .dq_pad_in   (dq_pad_in),
        .dqs_pad_in  (dqs_pad_in),
        .rx          (rx)
    );

endmodule

// ==== bench/tb_ddr_lane.sv ====
/*
 * tb_ddr_lane
 * testbench for the DDR3 byte lane with APB delay programming, pad loopback,
 * stream playback from the stim file, beat-level checks and a watchdog
 */
module tb_ddr_lane;
    timeunit 1ns;
    timeprecision 1ps;
    import phy_types_pkg::*;
    import phy_regs_pkg::*;

    localparam int MAX_WORDS = 16;               // longest record in the stim file

    logic clk_div, rst, psel, penable, pwrite, pready, pslverr, loop_en;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata, dq_pad_in;
    logic [3:0] dqs_pad_in;
    lane_tx_t tx;
    lane_pad_out_t pad;
    lane_rx_t rx;

    logic [31:0] stim_mem [0:255];
    logic [31:0] tx_dq [MAX_WORDS];              // words of the current record
    logic [3:0] dm_w [MAX_WORDS];
    logic [3:0] dqs_w [MAX_WORDS];
    lane_pad_out_t pad_cap [MAX_WORDS+2];
    lane_rx_t rx_cap [MAX_WORDS+2];
    logic [15:0] lfsr_state;
    logic [7:0] cur_od, cur_id;                  // active delay values as written
    longint wd_limit;
    int errors, tests, failed, test_err0;

    ddr_lane_top #(.NUM_DQ(8)) ddr_lane_top_inst (
        .clk_div(clk_div), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .tx(tx), .pad(pad), .dq_pad_in(dq_pad_in),
        .dqs_pad_in(dqs_pad_in), .rx(rx)
    );

    assign dq_pad_in = loop_en ? pad.dq : '0;    // pads looped back after reset
    assign dqs_pad_in = loop_en ? pad.dqs : '0;

    always #5 clk_div = ~clk_div;

    initial begin                                // watchdog
        wait (wd_limit > 0);
        #(wd_limit);
        $display("watchdog: run did not finish within %0d ns", wd_limit);
        $display("TEST FAILED");
        $finish;
    end

    // fibonacci lfsr with taps 16 14 13 11 and one step per bit
    function automatic logic [3:0] random_beats();
        logic [3:0] r;
        logic fb;
        for (int b = 0; b < 4; b++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r[b] = fb;
        end
        return r;
    endfunction

    // byte stream of the record shifted late by d beats with zeros around it
    function automatic logic [31:0] shift_dq(input int j, input int d, input int n);
        logic [31:0] w;
        int p;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            p = 4 * j + k - d;
            if (p >= 0 && p < 4 * n) w[k*8 +: 8] = tx_dq[p/4][(p%4)*8 +: 8];
        end
        return w;
    endfunction

    // sel 0 picks dm, 1 dqs and 2 the output enable that is low inside the record
    function automatic logic [3:0] shift_beats(input int sel, input int j, input int d,
                                               input int n);
        logic [3:0] w;
        int p;
        for (int k = 0; k < 4; k++) begin
            p = 4 * j + k - d;
            if (p >= 0 && p < 4 * n) begin
                case (sel)
                    0: w[k] = dm_w[p/4][p%4];
                    1: w[k] = dqs_w[p/4][p%4];
                    default: w[k] = 1'b0;
                endcase
            end else begin
                w[k] = (sel == 2);               // idle beats are tristated
            end
        end
        return w;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // called at a falling edge and returns at a falling edge with the bus idle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        paddr = addr;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk_div);
        penable = 1'b1;                          // access phase
        @(negedge clk_div);
        check_val("pready", 32'(pready), 32'h1); // zero wait states
        rdata = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic err;
        apb_xfer(1'b1, addr, data, rd, err);
        if (err) begin
            $display("unexpected pslverr on write to address %h", addr);
            errors++;
        end
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        if (err) begin
            $display("unexpected pslverr on read of address %h", addr);
            errors++;
        end
        check_val($sformatf("prdata[%h]", addr), rd, exp);
    endtask

    task automatic drive_idle();
        tx.dq = '0;
        tx.dm = '0;
        tx.dqs = '0;
        tx.dq_oe_n = '1;
        tx.dqs_oe_n = '1;
    endtask

    task automatic end_test(input int id, input string name);
        tests++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            failed++;
            $display("test %0d %s: failed with %0d errors", id, name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    // plays n words and samples pad 2 cycles and rx 4 cycles after each drive
    task automatic run_stream(input int n, input int od, input int idl);
        for (int s = 0; s < n + 6; s++) begin
            if (s >= 2 && s < n + 4) pad_cap[s-2] = pad;
            if (s >= 4) rx_cap[s-4] = rx;
            if (s < n) begin
                tx.dq = tx_dq[s];
                tx.dm = dm_w[s];
                tx.dqs = dqs_w[s];
                tx.dq_oe_n = '0;
                tx.dqs_oe_n = '0;
            end else begin
                drive_idle();
            end
            @(negedge clk_div);
        end
        for (int j = 0; j < n + 2; j++) begin
            check_val($sformatf("pad.dq[%0d]", j), pad_cap[j].dq, shift_dq(j, od, n));
            check_val($sformatf("pad.dm[%0d]", j), 32'(pad_cap[j].dm),
                      32'(shift_beats(0, j, od, n)));
            check_val($sformatf("pad.dqs[%0d]", j), 32'(pad_cap[j].dqs),
                      32'(shift_beats(1, j, od, n)));
            check_val($sformatf("pad.dq_oe_n[%0d]", j), 32'(pad_cap[j].dq_oe_n),
                      32'(shift_beats(2, j, od, n)));
            check_val($sformatf("pad.dqs_oe_n[%0d]", j), 32'(pad_cap[j].dqs_oe_n),
                      32'(shift_beats(2, j, od, n)));
            check_val($sformatf("rx.dq[%0d]", j), rx_cap[j].dq, shift_dq(j, od + idl, n));
            check_val($sformatf("rx.dqs[%0d]", j), 32'(rx_cap[j].dqs),
                      32'(shift_beats(1, j, od + idl, n)));
        end
    endtask

    // one file record holds a header, tx words and expected rx words
    task automatic run_record(inout int ptr);
        int tid, od, idl, n;
        logic [7:0] odv, idv;
        tid = int'(stim_mem[ptr]);
        od = int'(stim_mem[ptr+1]);
        idl = int'(stim_mem[ptr+2]);
        n = int'(stim_mem[ptr+3]);
        ptr += 4;
        if (n < 1 || n > MAX_WORDS || od > 7 || idl > 7 || od + idl > 8) begin
            $display("stimulus error: record %0d has a bad header", tid);
            errors++;
            ptr += 2 * n + 2;
            end_test(tid, "stream");
            return;
        end
        for (int j = 0; j < n; j++) begin
            tx_dq[j] = stim_mem[ptr+j];
            dm_w[j] = random_beats();
            dqs_w[j] = random_beats();
        end
        ptr += n;
        for (int j = 0; j < n + 2; j++) begin
            if (stim_mem[ptr+j] !== shift_dq(j, od + idl, n)) begin
                $display("stimulus error: record %0d expected word %0d %s",
                         tid, j, "disagrees with the beat rule");
                errors++;
            end
        end
        ptr += n + 2;
        odv = 8'(od) | 8'ha0;                    // upper bits are stored but set no delay
        idv = 8'(idl) | 8'h50;
        for (int t = 0; t < NUM_ODLY; t++) write_reg(REG_ODLY_BASE + 8'(4 * t), 32'(odv));
        for (int t = 0; t < NUM_IDLY; t++) write_reg(REG_IDLY_BASE + 8'(4 * t), 32'(idv));
        read_check(REG_ODLY_BASE, 32'(cur_od));  // active copy still holds the old value
        read_check(REG_IDLY_BASE + 8'h20, 32'(cur_id));
        write_reg(REG_SET, 32'h1);
        read_check(REG_ODLY_BASE, 32'(odv));
        read_check(REG_ODLY_BASE + 8'h24, 32'(odv));  // dm
        read_check(REG_IDLY_BASE + 8'h20, 32'(idv));  // dqs
        read_check(REG_SET, 32'h0);
        cur_od = odv;
        cur_id = idv;
        run_stream(n, od, idl);
        end_test(tid, $sformatf("stream od %0d id %0d", od, idl));
    endtask

    initial begin
        int ptr, nrec;
        longint total;
        logic [31:0] rd;
        logic err;
        logic [7:0] bad_addr [5];
        clk_div = 1'b0;
        rst = 1'b1;
        loop_en = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        drive_idle();
        lfsr_state = 16'd81;
        cur_od = '0;
        cur_id = '0;
        errors = 0;
        tests = 0;
        failed = 0;
        test_err0 = 0;
        wd_limit = 0;
        bad_addr = '{8'h64, 8'h28, 8'h88, 8'h01, 8'hc0};
        $readmemh("bench/lane_stim.txt", stim_mem);
        nrec = int'(stim_mem[0]);
        total = 0;
        ptr = 1;
        for (int r = 0; r < nrec; r++) begin
            total += longint'(stim_mem[ptr+3]);
            ptr += 6 + 2 * int'(stim_mem[ptr+3]);
        end
        wd_limit = (total + 50 * (nrec + 3)) * 10;
        repeat (5) @(posedge clk_div);
        @(negedge clk_div);
        rst = 1'b0;
        loop_en = 1'b1;

        // reset state
        check_val("pad.dq_oe_n", 32'(pad.dq_oe_n), 32'hf);
        check_val("pad.dqs_oe_n", 32'(pad.dqs_oe_n), 32'hf);
        check_val("pad.odt_off", 32'({pad.odt_off_dqs, pad.odt_off_dq}), 32'h3);
        for (int t = 0; t < NUM_ODLY; t++) read_check(REG_ODLY_BASE + 8'(4 * t), 32'h0);
        for (int t = 0; t < NUM_IDLY; t++) read_check(REG_IDLY_BASE + 8'(4 * t), 32'h0);
        end_test(1, "reset state");

        ptr = 1;
        for (int r = 0; r < nrec; r++) run_record(ptr);

        // odt bits reach the pads one cycle after the register write
        write_reg(REG_ODT, 32'h1);
        check_val("pad.odt_off early", 32'({pad.odt_off_dqs, pad.odt_off_dq}), 32'h3);
        @(negedge clk_div);
        check_val("pad.odt_off", 32'({pad.odt_off_dqs, pad.odt_off_dq}), 32'h1);
        write_reg(REG_ODT, 32'h2);
        @(negedge clk_div);
        check_val("pad.odt_off", 32'({pad.odt_off_dqs, pad.odt_off_dq}), 32'h2);
        read_check(REG_ODT, 32'h2);
        end_test(7, "odt control");

        // unmapped and dm input delay accesses
        for (int a = 0; a < 5; a++) begin
            apb_xfer(1'b1, bad_addr[a], 32'hff, rd, err);
            if (!err) begin
                $display("no pslverr on write to address %h", bad_addr[a]);
                errors++;
            end
        end
        apb_xfer(1'b0, 8'h64, 32'h0, rd, err);
        if (!err) begin
            $display("no pslverr on read of the dm input delay");
            errors++;
        end
        write_reg(REG_SET, 32'h1);               // would expose any pending change
        read_check(REG_ODLY_BASE, 32'(cur_od));
        read_check(REG_ODLY_BASE + 8'h24, 32'(cur_od));
        read_check(REG_IDLY_BASE, 32'(cur_id));
        read_check(REG_IDLY_BASE + 8'h20, 32'(cur_id));
        read_check(REG_ODT, 32'h2);
        end_test(8, "apb errors");

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/lane_stim.txt ====
// lane stream records in hex: record count first, then per record
// test id, out delay, in delay, n, n tx dq words, n+2 expected rx dq words
5
// all delays zero
2 0 0 3
44332211 88776655 ccbbaa99
44332211 88776655 ccbbaa99 00000000 00000000
// 1 out plus 2 in, three beats late
3 1 2 3
04030201 08070605 0c0b0a09
01000000 05040302 09080706 000c0b0a 00000000
// five beats across word edges
4 2 3 2
deadbeef 01234567
00000000 adbeef00 234567de 00000001
// input delay only, one full word
5 0 4 2
0f1e2d3c 4b5a6978
00000000 0f1e2d3c 4b5a6978 00000000
// largest output delay
6 7 1 1
80402010
00000000 00000000 80402010

// ==== project.f ====
common/phy_types_pkg.sv
common/phy_regs_pkg.sv
logic/apb_delay_regs.sv
byte_lane/lane_bit_slice.sv
byte_lane/dqs_slice.sv
byte_lane/byte_lane.sv
logic/ddr_lane_top.sv
bench/tb_ddr_lane.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the byte lane testbench with Verilator, run it, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_ddr_lane \
    -o tb_ddr_lane > sim.log 2>&1 &&
./obj_dir/tb_ddr_lane >> sim.log 2>&1
grep -q "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
